/* logic/pio_pkg.sv */
// Widths, instruction field enums and word helpers shared by the state machine
`default_nettype none

package pio_pkg;

  localparam int DATA_W  = 32;
  localparam int INSTR_W = 16;
  localparam int PC_W    = 5;
  localparam int COUNT_W = 6;   // Shift count spans 0 to 32

  typedef enum logic [2:0] {
    OP_JMP, OP_WAIT, OP_IN, OP_OUT,
    OP_PUSHPULL, OP_MOV, OP_IRQ, OP_SET
  } pio_op_e;

  typedef enum logic [2:0] {
    ALWAYS, X_ZERO, X_NZ_DEC, Y_ZERO,
    Y_NZ_DEC, X_NE_Y, PIN, OSRE_NOT
  } jmp_cond_e;

  // Sources read LOC_PINDIRS as a reserved code
  typedef enum logic [2:0] {
    LOC_PINS, LOC_X, LOC_Y, LOC_NULL,
    LOC_PINDIRS, LOC_PC, LOC_ISR, LOC_OSR
  } loc_e;

  typedef enum logic [1:0] {
    MOV_NONE, MOV_INVERT, MOV_REVERSE, MOV_RSVD
  } mov_op_e;

  function automatic logic [DATA_W-1:0] reverse_bits(input logic [DATA_W-1:0] word);
    logic [DATA_W-1:0] res;
    for (int i = 0; i < DATA_W; i++) begin
      res[i] = word[DATA_W-1-i];  // Bit 0 swaps with bit 31
    end
    return res;
  endfunction

  function automatic logic [DATA_W-1:0] apply_mov_op(input logic [DATA_W-1:0] word,
                                                     input mov_op_e op);
    case (op)
      MOV_INVERT:  return ~word;
      MOV_REVERSE: return reverse_bits(word);
      default:     return word;   // Reserved code passes through
    endcase
  endfunction

endpackage

`default_nettype wire

/* logic/sm_exec.sv */
// Instruction decode and execute
// Produces register, pin and FIFO strobes plus the value to write
`timescale 1ns/1ps
`default_nettype none

module sm_exec (
  input  logic                        en,
  input  logic [pio_pkg::INSTR_W-1:0] instr,
  input  logic [pio_pkg::DATA_W-1:0]  input_pins,
  input  logic [pio_pkg::DATA_W-1:0]  din,
  input  logic                        full,
  input  logic                        empty,
  input  logic [pio_pkg::PC_W-1:0]    jmp_pin,
  input  logic [4:0]                  pins_in_base,
  input  logic [4:0]                  isr_threshold,
  input  logic [4:0]                  osr_threshold,
  input  logic [pio_pkg::DATA_W-1:0]  x,
  input  logic [pio_pkg::DATA_W-1:0]  y,
  input  logic [pio_pkg::DATA_W-1:0]  isr,
  input  logic [pio_pkg::COUNT_W-1:0] isr_count,
  input  logic [pio_pkg::DATA_W-1:0]  osr,
  input  logic [pio_pkg::COUNT_W-1:0] osr_count,
  input  logic [pio_pkg::DATA_W-1:0]  shift_out,   // Next OUT bits from the OSR
  output logic [pio_pkg::DATA_W-1:0]  new_val,
  output logic                        set_x,
  output logic                        dec_x,
  output logic                        set_y,
  output logic                        dec_y,
  output logic                        jmp,
  output logic                        stall,
  output logic                        isr_load,
  output logic                        isr_shift,
  output logic                        osr_load,
  output logic                        osr_shift,
  output logic [4:0]                  shift_amt,
  output logic                        pin_write,
  output logic                        dir_write,
  output logic                        pin_group,   // High selects the SET group
  output logic                        push,
  output logic                        pull,
  output logic [pio_pkg::DATA_W-1:0]  dout
);
  import pio_pkg::*;

  pio_op_e             opcode;
  jmp_cond_e           cond;
  loc_e                loc;        // Field [7:5]
  loc_e                mov_src;
  loc_e                src_sel;
  mov_op_e             mov_op;
  logic [4:0]          arg;
  logic [2*DATA_W-1:0] pins_dbl;
  logic [DATA_W-1:0]   in_pins;
  logic [DATA_W-1:0]   src_val;
  logic                src_ok;
  logic [COUNT_W-1:0]  isr_thr;
  logic [COUNT_W-1:0]  osr_thr;

  assign opcode    = pio_op_e'(instr[15:13]);
  assign cond      = jmp_cond_e'(instr[7:5]);
  assign loc       = loc_e'(instr[7:5]);
  assign mov_src   = loc_e'(instr[2:0]);
  assign mov_op    = mov_op_e'(instr[4:3]);
  assign arg       = instr[4:0];
  assign shift_amt = arg;

  // Input pins rotated so that the input base lands on bit 0
  assign pins_dbl = {input_pins, input_pins} >> pins_in_base;
  assign in_pins  = pins_dbl[DATA_W-1:0];

  // Threshold of 0 stands for all 32 bits
  assign isr_thr = (isr_threshold == '0) ? COUNT_W'(DATA_W) : {1'b0, isr_threshold};
  assign osr_thr = (osr_threshold == '0) ? COUNT_W'(DATA_W) : {1'b0, osr_threshold};

  assign src_sel = (opcode == OP_MOV) ? mov_src : loc;

  always_comb begin
    src_ok = 1'b1;
    case (src_sel)
      LOC_PINS: src_val = in_pins;
      LOC_X:    src_val = x;
      LOC_Y:    src_val = y;
      LOC_NULL: src_val = '0;
      LOC_ISR:  src_val = isr;
      LOC_OSR:  src_val = osr;
      default: begin                // Reserved and status codes
        src_val = '0;
        src_ok  = 1'b0;
      end
    endcase
  end

  always_comb begin
    new_val   = '0;
    set_x     = 1'b0;
    dec_x     = 1'b0;
    set_y     = 1'b0;
    dec_y     = 1'b0;
    jmp       = 1'b0;
    stall     = 1'b0;
    isr_load  = 1'b0;
    isr_shift = 1'b0;
    osr_load  = 1'b0;
    osr_shift = 1'b0;
    pin_write = 1'b0;
    dir_write = 1'b0;
    pin_group = 1'b0;
    push      = 1'b0;
    pull      = 1'b0;
    dout      = '0;
    if (en) begin
      case (opcode)
        OP_JMP: begin
          new_val = DATA_W'(arg);
          case (cond)
            ALWAYS:   jmp = 1'b1;
            X_ZERO:   jmp = (x == '0);
            X_NZ_DEC: begin
              jmp   = (x != '0);
              dec_x = (x != '0);
            end
            Y_ZERO:   jmp = (y == '0);
            Y_NZ_DEC: begin
              jmp   = (y != '0);
              dec_y = (y != '0);
            end
            X_NE_Y:   jmp = (x != y);
            PIN:      jmp = input_pins[jmp_pin];
            OSRE_NOT: jmp = (osr_count < osr_thr);
          endcase
        end
        OP_WAIT: begin
          case (instr[6:5])
            2'd0:    stall = (input_pins[arg] != instr[7]);  // Absolute GPIO
            2'd1:    stall = (in_pins[arg] != instr[7]);     // Relative to input base
            default: stall = 1'b0;
          endcase
        end
        OP_IN: begin
          isr_shift = src_ok;
          new_val   = src_val;
        end
        OP_OUT: begin
          new_val   = shift_out;
          osr_shift = (loc inside {LOC_PINS, LOC_X, LOC_Y, LOC_NULL, LOC_PINDIRS});
          pin_write = (loc == LOC_PINS);
          dir_write = (loc == LOC_PINDIRS);
          set_x     = (loc == LOC_X);
          set_y     = (loc == LOC_Y);
        end
        OP_PUSHPULL: begin
          if (!instr[7]) begin
            if (!instr[6] || isr_count >= isr_thr) begin  // Push, gated by iffull
              stall    = instr[5] && full;
              push     = !full;
              isr_load = !stall;
              dout     = full ? '0 : isr;
            end
          end else if (!instr[6] || osr_count >= osr_thr) begin  // Pull, gated by ifempty
            stall    = instr[5] && empty;
            pull     = !empty;
            osr_load = !stall;
            new_val  = empty ? x : din;  // Empty non-blocking pull takes X
          end
        end
        OP_MOV: begin
          new_val   = apply_mov_op(src_val, mov_op);
          pin_write = src_ok && (loc == LOC_PINS);
          set_x     = src_ok && (loc == LOC_X);
          set_y     = src_ok && (loc == LOC_Y);
          isr_load  = src_ok && (loc == LOC_ISR);
          osr_load  = src_ok && (loc == LOC_OSR);
        end
        OP_SET: begin
          new_val   = DATA_W'(arg);
          pin_group = 1'b1;
          pin_write = (loc == LOC_PINS);
          dir_write = (loc == LOC_PINDIRS);
          set_x     = (loc == LOC_X);
          set_y     = (loc == LOC_Y);
        end
        default: stall = 1'b0;  // IRQ runs as a no-op
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/sm_isr.sv */
// Input shift register with saturating shift count
`timescale 1ns/1ps
`default_nettype none

module sm_isr (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        en,
  input  logic                        load,
  input  logic                        shift,
  input  logic                        dir,     // 1 shifts right
  input  logic [4:0]                  amount,
  input  logic [pio_pkg::DATA_W-1:0]  din,
  output logic [pio_pkg::DATA_W-1:0]  value,
  output logic [pio_pkg::COUNT_W-1:0] count
);
  import pio_pkg::*;

  logic [COUNT_W-1:0] n;
  logic [COUNT_W:0]   sum;
  logic [DATA_W-1:0]  mask;
  logic [DATA_W-1:0]  shifted;

  assign n    = (amount == '0) ? COUNT_W'(DATA_W) : {1'b0, amount};  // 0 means 32
  assign sum  = count + n;
  assign mask = ~({DATA_W{1'b1}} << n);

  // New bits enter at the left on a right shift, at the right otherwise
  assign shifted = dir ? ((value >> n) | (din << (COUNT_W'(DATA_W) - n)))
                       : ((value << n) | (din & mask));

  always_ff @(posedge clk) begin
    if (reset) begin
      value <= '0;
      count <= '0;
    end else if (en) begin
      if (load) begin
        value <= din;
        count <= '0;
      end else if (shift) begin
        value <= shifted;
        count <= (sum > DATA_W) ? COUNT_W'(DATA_W) : sum[COUNT_W-1:0];
      end
    end
  end

endmodule

`default_nettype wire

/* logic/sm_osr.sv */
// Output shift register with saturating shift count
`timescale 1ns/1ps
`default_nettype none

module sm_osr (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        en,
  input  logic                        load,
  input  logic                        shift,
  input  logic                        dir,     // 1 shifts right
  input  logic [4:0]                  amount,
  input  logic [pio_pkg::DATA_W-1:0]  din,
  output logic [pio_pkg::DATA_W-1:0]  value,
  output logic [pio_pkg::COUNT_W-1:0] count,
  output logic [pio_pkg::DATA_W-1:0]  shift_out
);
  import pio_pkg::*;

  logic [COUNT_W-1:0] n;
  logic [COUNT_W:0]   sum;
  logic [DATA_W-1:0]  mask;

  assign n    = (amount == '0) ? COUNT_W'(DATA_W) : {1'b0, amount};  // 0 means 32
  assign sum  = count + n;
  assign mask = ~({DATA_W{1'b1}} << n);

  // Right-justified bits leaving at the low end or the high end
  assign shift_out = dir ? (value & mask) : (value >> (COUNT_W'(DATA_W) - n));

  always_ff @(posedge clk) begin
    if (reset) begin
      value <= '0;
      count <= COUNT_W'(DATA_W);   // Starts empty
    end else if (en) begin
      if (load) begin
        value <= din;
        count <= '0;
      end else if (shift) begin
        value <= dir ? (value >> n) : (value << n);
        count <= (sum > DATA_W) ? COUNT_W'(DATA_W) : sum[COUNT_W-1:0];
      end
    end
  end

endmodule

`default_nettype wire

/* logic/sm_pc.sv */
// Program counter with jump, stall and wrap
`timescale 1ns/1ps
`default_nettype none

module sm_pc (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     en,
  input  logic                     jmp,
  input  logic                     stall,
  input  logic [pio_pkg::PC_W-1:0] target,
  input  logic [pio_pkg::PC_W-1:0] wrap_top,
  input  logic [pio_pkg::PC_W-1:0] wrap_bottom,
  output logic [pio_pkg::PC_W-1:0] pc
);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (en && !stall) begin
      if (jmp) pc <= target;
      else if (pc == wrap_top) pc <= wrap_bottom;  // Program wrap
      else pc <= pc + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/sm_pins.sv */
// Output pin and pin direction registers
// Writes a count of bits at a group base, wrapping modulo 32
`timescale 1ns/1ps
`default_nettype none

module sm_pins (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        en,
  input  logic                        pin_write,
  input  logic                        dir_write,
  input  logic                        pin_group,   // High selects the SET group
  input  logic [4:0]                  out_base,
  input  logic [pio_pkg::COUNT_W-1:0] out_count,
  input  logic [4:0]                  set_base,
  input  logic [2:0]                  set_count,
  input  logic [pio_pkg::DATA_W-1:0]  din,
  output logic [pio_pkg::DATA_W-1:0]  output_pins,
  output logic [pio_pkg::DATA_W-1:0]  pin_directions
);
  import pio_pkg::*;

  logic [4:0]          base;
  logic [COUNT_W-1:0]  cnt;
  logic [DATA_W-1:0]   low_mask;
  logic [2*DATA_W-1:0] mask_dbl;
  logic [2*DATA_W-1:0] data_dbl;
  logic [DATA_W-1:0]   wmask;
  logic [DATA_W-1:0]   wdata;

  assign base     = pin_group ? set_base : out_base;
  assign cnt      = pin_group ? COUNT_W'(set_count) : out_count;
  assign low_mask = ~({DATA_W{1'b1}} << cnt);

  // Rotate left by the base so bit 0 lands on the first pin
  assign mask_dbl = {low_mask, low_mask} << base;
  assign data_dbl = {din & low_mask, din & low_mask} << base;
  assign wmask    = mask_dbl[2*DATA_W-1:DATA_W];
  assign wdata    = data_dbl[2*DATA_W-1:DATA_W];

  always_ff @(posedge clk) begin
    if (reset) begin
      output_pins    <= '0;
      pin_directions <= '0;
    end else if (en) begin
      if (pin_write) output_pins <= (output_pins & ~wmask) | (wdata & wmask);
      if (dir_write) pin_directions <= (pin_directions & ~wmask) | (wdata & wmask);
    end
  end

endmodule

`default_nettype wire

/* logic/sm_scratch.sv */
// Scratch register with load and decrement, used for X and Y
`timescale 1ns/1ps
`default_nettype none

module sm_scratch (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       en,
  input  logic                       set,
  input  logic                       dec,
  input  logic [pio_pkg::DATA_W-1:0] din,
  output logic [pio_pkg::DATA_W-1:0] value
);

  always_ff @(posedge clk) begin
    if (reset) begin
      value <= '0;
    end else if (en) begin
      if (set) value <= din;
      else if (dec) value <= value - 1'b1;  // Post-decrement of JMP
    end
  end

endmodule

`default_nettype wire

/* logic/sm_top.sv */
// State machine top level
// Ties the decoder to the pc, scratch, shift and pin registers
`timescale 1ns/1ps
`default_nettype none

module sm_top (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        en,
  input  logic [pio_pkg::INSTR_W-1:0] instr,
  input  logic [pio_pkg::DATA_W-1:0]  input_pins,
  input  logic [pio_pkg::DATA_W-1:0]  din,
  input  logic                        full,
  input  logic                        empty,
  input  logic [pio_pkg::PC_W-1:0]    wrap_top,
  input  logic [pio_pkg::PC_W-1:0]    wrap_bottom,
  input  logic [pio_pkg::PC_W-1:0]    jmp_pin,
  input  logic [4:0]                  pins_in_base,
  input  logic [4:0]                  pins_out_base,
  input  logic [4:0]                  pins_set_base,
  input  logic [pio_pkg::COUNT_W-1:0] pins_out_count,
  input  logic [2:0]                  pins_set_count,
  input  logic                        in_shift_dir,
  input  logic                        out_shift_dir,
  input  logic [4:0]                  isr_threshold,
  input  logic [4:0]                  osr_threshold,
  output logic [pio_pkg::PC_W-1:0]    pc,
  output logic                        push,
  output logic                        pull,
  output logic [pio_pkg::DATA_W-1:0]  dout,
  output logic [pio_pkg::DATA_W-1:0]  output_pins,
  output logic [pio_pkg::DATA_W-1:0]  pin_directions
);
  import pio_pkg::*;

  logic [DATA_W-1:0]  new_val;
  logic               set_x;
  logic               dec_x;
  logic               set_y;
  logic               dec_y;
  logic               jmp;
  logic               stall;
  logic               isr_load;
  logic               isr_shift;
  logic               osr_load;
  logic               osr_shift;
  logic [4:0]         shift_amt;
  logic               pin_write;
  logic               dir_write;
  logic               pin_group;
  logic [DATA_W-1:0]  x;
  logic [DATA_W-1:0]  y;
  logic [DATA_W-1:0]  isr;
  logic [COUNT_W-1:0] isr_count;
  logic [DATA_W-1:0]  osr;
  logic [COUNT_W-1:0] osr_count;
  logic [DATA_W-1:0]  shift_out;

  sm_exec exec_i (
    .en(en), .instr(instr), .input_pins(input_pins), .din(din),
    .full(full), .empty(empty), .jmp_pin(jmp_pin), .pins_in_base(pins_in_base),
    .isr_threshold(isr_threshold), .osr_threshold(osr_threshold),
    .x(x), .y(y), .isr(isr), .isr_count(isr_count), .osr(osr),
    .osr_count(osr_count), .shift_out(shift_out), .new_val(new_val),
    .set_x(set_x), .dec_x(dec_x), .set_y(set_y), .dec_y(dec_y),
    .jmp(jmp), .stall(stall), .isr_load(isr_load), .isr_shift(isr_shift),
    .osr_load(osr_load), .osr_shift(osr_shift), .shift_amt(shift_amt),
    .pin_write(pin_write), .dir_write(dir_write), .pin_group(pin_group),
    .push(push), .pull(pull), .dout(dout)
  );

  sm_pc pc_i (
    .clk(clk), .reset(reset), .en(en), .jmp(jmp), .stall(stall),
    .target(new_val[PC_W-1:0]), .wrap_top(wrap_top), .wrap_bottom(wrap_bottom),
    .pc(pc)
  );

  sm_scratch x_reg (
    .clk(clk), .reset(reset), .en(en), .set(set_x), .dec(dec_x),
    .din(new_val), .value(x)
  );

  sm_scratch y_reg (
    .clk(clk), .reset(reset), .en(en), .set(set_y), .dec(dec_y),
    .din(new_val), .value(y)
  );

  sm_isr isr_i (
    .clk(clk), .reset(reset), .en(en), .load(isr_load), .shift(isr_shift),
    .dir(in_shift_dir), .amount(shift_amt), .din(new_val), .value(isr),
    .count(isr_count)
  );

  sm_osr osr_i (
    .clk(clk), .reset(reset), .en(en), .load(osr_load), .shift(osr_shift),
    .dir(out_shift_dir), .amount(shift_amt), .din(new_val), .value(osr),
    .count(osr_count), .shift_out(shift_out)
  );

  sm_pins pins_i (
    .clk(clk), .reset(reset), .en(en), .pin_write(pin_write),
    .dir_write(dir_write), .pin_group(pin_group), .out_base(pins_out_base),
    .out_count(pins_out_count), .set_base(pins_set_base),
    .set_count(pins_set_count), .din(new_val), .output_pins(output_pins),
    .pin_directions(pin_directions)
  );

endmodule

`default_nettype wire

/* sources.f */
logic/pio_pkg.sv
logic/sm_exec.sv
logic/sm_pc.sv
logic/sm_scratch.sv
logic/sm_isr.sv
logic/sm_osr.sv
logic/sm_pins.sv
logic/sm_top.sv
verif/sm_tb.sv

/* verif/sm_tb.sv */
// Table-driven testbench for the state machine top level
// Program rows with expected pc, FIFO strobes, pins and pin directions
`timescale 1ns/1ps
`default_nettype none

module sm_tb;
  import pio_pkg::*;

  localparam int NUM_ROWS = 34;

  logic                clk = 1'b0;
  logic                reset;
  logic                en;
  logic [INSTR_W-1:0]  instr;
  logic [DATA_W-1:0]   input_pins;
  logic [DATA_W-1:0]   din;
  logic                full;
  logic                empty;
  logic [PC_W-1:0]     wrap_top;
  logic [PC_W-1:0]     wrap_bottom;
  logic [PC_W-1:0]     jmp_pin;
  logic [4:0]          pins_in_base;
  logic [4:0]          pins_out_base;
  logic [4:0]          pins_set_base;
  logic [COUNT_W-1:0]  pins_out_count;
  logic [2:0]          pins_set_count;
  logic                in_shift_dir;
  logic                out_shift_dir;
  logic [4:0]          isr_threshold;
  logic [4:0]          osr_threshold;
  logic [PC_W-1:0]     pc;
  logic                push;
  logic                pull;
  logic [DATA_W-1:0]   dout;
  logic [DATA_W-1:0]   output_pins;
  logic [DATA_W-1:0]   pin_directions;

  // One row of stimulus and expected values per clock cycle
  logic [INSTR_W-1:0]  t_instr [NUM_ROWS];
  logic [DATA_W-1:0]   t_pins  [NUM_ROWS];
  logic [DATA_W-1:0]   t_din   [NUM_ROWS];
  logic                t_full  [NUM_ROWS];
  logic                t_empty [NUM_ROWS];
  logic [PC_W-1:0]     t_pc    [NUM_ROWS];
  logic                t_push  [NUM_ROWS];
  logic                t_pull  [NUM_ROWS];
  logic [DATA_W-1:0]   t_dout  [NUM_ROWS];
  logic [DATA_W-1:0]   t_opins [NUM_ROWS];
  logic [DATA_W-1:0]   t_dirs  [NUM_ROWS];
  int                  n_rows = 0;
  int                  seed = 32'he93c;
  logic [DATA_W-1:0]   r_a;
  logic [DATA_W-1:0]   r_b;

  sm_top sm_top_i (
    .clk(clk), .reset(reset), .en(en), .instr(instr), .input_pins(input_pins),
    .din(din), .full(full), .empty(empty), .wrap_top(wrap_top),
    .wrap_bottom(wrap_bottom), .jmp_pin(jmp_pin), .pins_in_base(pins_in_base),
    .pins_out_base(pins_out_base), .pins_set_base(pins_set_base),
    .pins_out_count(pins_out_count), .pins_set_count(pins_set_count),
    .in_shift_dir(in_shift_dir), .out_shift_dir(out_shift_dir),
    .isr_threshold(isr_threshold), .osr_threshold(osr_threshold), .pc(pc),
    .push(push), .pull(pull), .dout(dout), .output_pins(output_pins),
    .pin_directions(pin_directions)
  );

  always #10 clk = ~clk;  // 20 ns period

  // Opcode, middle field [7:5] and argument [4:0] around a zero delay field
  function automatic logic [INSTR_W-1:0] encode(input logic [2:0] op, input logic [2:0] mid,
                                                input logic [4:0] arg);
    return {op, 5'b0, mid, arg};
  endfunction

  function automatic logic [DATA_W-1:0] mirror_word(input logic [DATA_W-1:0] w);
    logic [DATA_W-1:0] m;
    for (int i = 0; i < DATA_W; i++) begin
      m[DATA_W-1-i] = w[i];
    end
    return m;
  endfunction

  task automatic compare(input string what, input int row, input logic [DATA_W-1:0] got,
                         input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: row %0d %s is %h, expected %h", $time, row, what, got, exp);
      $display("Result: FAILED");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  task automatic add_row(input logic [INSTR_W-1:0] ins, input logic [DATA_W-1:0] pins,
                         input logic [DATA_W-1:0] d, input logic f, input logic e,
                         input logic [PC_W-1:0] exp_pc, input logic exp_push,
                         input logic exp_pull, input logic [DATA_W-1:0] exp_dout,
                         input logic [DATA_W-1:0] exp_pins, input logic [DATA_W-1:0] exp_dirs);
    t_instr[n_rows] = ins;
    t_pins[n_rows]  = pins;
    t_din[n_rows]   = d;
    t_full[n_rows]  = f;
    t_empty[n_rows] = e;
    t_pc[n_rows]    = exp_pc;
    t_push[n_rows]  = exp_push;
    t_pull[n_rows]  = exp_pull;
    t_dout[n_rows]  = exp_dout;
    t_opins[n_rows] = exp_pins;
    t_dirs[n_rows]  = exp_dirs;
    n_rows++;
  endtask

  // Set group at base 4 width 3, out group at base 8 width 8, wrap 15 to 1
  task automatic build_table();
    logic [DATA_W-1:0] p0;
    logic [DATA_W-1:0] p1;
    logic [DATA_W-1:0] pa;
    logic [DATA_W-1:0] pb;
    logic [DATA_W-1:0] p2;
    logic [DATA_W-1:0] rv;
    r_a = $random(seed);
    r_b = $random(seed);
    p0 = 32'h0000_0050;                  // SET PINS 101 at pin 4
    p1 = 32'h0000_EC50;                  // Low byte of ~0x13 on the out group
    pa = {16'h0, r_a[31:24], 8'h50};     // MSB first out of the OSR
    pb = {16'h0, r_a[23:16], 8'h50};
    p2 = 32'h0000_0350;                  // X copied by the empty pull
    rv = mirror_word(r_a << 16);
    add_row(encode(OP_SET, LOC_PINS, 5'h15), 0, r_b, 0, 0, 1, 0, 0, 0, p0, 0);
    add_row(encode(OP_SET, LOC_PINDIRS, 5'h06), 0, r_b, 0, 0, 2, 0, 0, 0, p0, 32'h60);
    add_row(encode(OP_SET, LOC_X, 5'h13), 0, r_b, 0, 0, 3, 0, 0, 0, p0, 32'h60);
    add_row(encode(OP_MOV, LOC_PINS, {MOV_INVERT, LOC_X}), 0, r_b, 0, 0, 4, 0, 0, 0, p1, 32'h60);
    add_row(encode(OP_SET, LOC_X, 5'd2), 0, r_b, 0, 0, 5, 0, 0, 0, p1, 32'h60);
    add_row(encode(OP_JMP, X_NZ_DEC, 5'd5), 0, r_b, 0, 0, 5, 0, 0, 0, p1, 32'h60);
    add_row(encode(OP_JMP, X_NZ_DEC, 5'd5), 0, r_b, 0, 0, 5, 0, 0, 0, p1, 32'h60);
    add_row(encode(OP_JMP, X_NZ_DEC, 5'd5), 0, r_b, 0, 0, 6, 0, 0, 0, p1, 32'h60);
    add_row(encode(OP_SET, LOC_Y, 5'd3), 0, r_b, 0, 0, 7, 0, 0, 0, p1, 32'h60);
    add_row(encode(OP_JMP, X_NE_Y, 5'd9), 0, r_b, 0, 0, 9, 0, 0, 0, p1, 32'h60);
    add_row(encode(OP_JMP, PIN, 5'd3), 0, r_b, 0, 0, 10, 0, 0, 0, p1, 32'h60);
    add_row(encode(OP_JMP, PIN, 5'd14), 32'h20, r_b, 0, 0, 14, 0, 0, 0, p1, 32'h60);
    add_row(encode(OP_SET, LOC_X, 5'd3), 0, r_b, 0, 0, 15, 0, 0, 0, p1, 32'h60);
    add_row(encode(OP_MOV, LOC_Y, {MOV_NONE, LOC_X}), 0, r_b, 0, 0, 1, 0, 0, 0, p1, 32'h60);
    add_row(encode(OP_JMP, X_NE_Y, 5'd20), 0, r_b, 0, 0, 2, 0, 0, 0, p1, 32'h60);
    add_row(encode(OP_PUSHPULL, 3'b101, 0), 0, r_b, 0, 1, 2, 0, 0, 0, p1, 32'h60);
    add_row(encode(OP_PUSHPULL, 3'b101, 0), 0, r_b, 0, 1, 2, 0, 0, 0, p1, 32'h60);
    add_row(encode(OP_PUSHPULL, 3'b101, 0), 0, r_a, 0, 0, 3, 0, 1, 0, p1, 32'h60);
    add_row(encode(OP_OUT, LOC_PINS, 5'd8), 0, r_b, 0, 0, 4, 0, 0, 0, pa, 32'h60);
    add_row(encode(OP_OUT, LOC_PINS, 5'd8), 0, r_b, 0, 0, 5, 0, 0, 0, pb, 32'h60);
    add_row(encode(OP_MOV, LOC_ISR, {MOV_REVERSE, LOC_OSR}), 0, r_b, 0, 0, 6, 0, 0, 0, pb, 32'h60);
    add_row(encode(OP_PUSHPULL, 3'b000, 0), 0, r_b, 0, 0, 7, 1, 0, rv, pb, 32'h60);
    add_row(encode(OP_PUSHPULL, 3'b100, 0), 0, r_b, 0, 1, 8, 0, 0, 0, pb, 32'h60);
    add_row(encode(OP_OUT, LOC_PINS, 5'd0), 0, r_b, 0, 0, 9, 0, 0, 0, p2, 32'h60);
    add_row(encode(OP_IN, LOC_PINS, 5'd4), 32'hB4, r_b, 0, 0, 10, 0, 0, 0, p2, 32'h60);
    add_row(encode(OP_IN, LOC_X, 5'd8), 0, r_b, 0, 0, 11, 0, 0, 0, p2, 32'h60);
    add_row(encode(OP_PUSHPULL, 3'b001, 0), 0, r_b, 1, 0, 11, 0, 0, 0, p2, 32'h60);
    add_row(encode(OP_PUSHPULL, 3'b001, 0), 0, r_b, 0, 0, 12, 1, 0, 32'hD03, p2, 32'h60);
    add_row(encode(OP_WAIT, 3'b100, 5'd7), 0, r_b, 0, 0, 12, 0, 0, 0, p2, 32'h60);
    add_row(encode(OP_WAIT, 3'b100, 5'd7), 32'h80, r_b, 0, 0, 13, 0, 0, 0, p2, 32'h60);
    add_row(encode(OP_WAIT, 3'b001, 5'd3), 32'h20, r_b, 0, 0, 13, 0, 0, 0, p2, 32'h60);
    add_row(encode(OP_WAIT, 3'b001, 5'd3), 0, r_b, 0, 0, 14, 0, 0, 0, p2, 32'h60);
    add_row(encode(OP_JMP, OSRE_NOT, 5'd0), 0, r_b, 0, 0, 15, 0, 0, 0, p2, 32'h60);
    add_row(encode(OP_SET, LOC_PINDIRS, 5'h03), 0, r_b, 0, 0, 1, 0, 0, 0, p2, 32'h30);
  endtask

  initial begin
    #((NUM_ROWS + 10) * 20);
    $display("Watchdog timeout: the program rows did not complete in time");
    $display("Result: FAILED");
    $fatal(1, "Simulation timed out");
  end

  initial begin
    reset = 1'b1;
    en = 1'b1;
    instr = '0;
    input_pins = '0;
    din = '0;
    full = 1'b0;
    empty = 1'b0;
    wrap_top = 5'd15;
    wrap_bottom = 5'd1;
    jmp_pin = 5'd5;
    pins_in_base = 5'd2;
    pins_out_base = 5'd8;
    pins_set_base = 5'd4;
    pins_out_count = 6'd8;
    pins_set_count = 3'd3;
    in_shift_dir = 1'b0;    // Shift left on IN
    out_shift_dir = 1'b0;   // MSB first on OUT
    isr_threshold = '0;
    osr_threshold = '0;
    build_table();
    compare("table size", 0, n_rows, NUM_ROWS);
    repeat (4) @(posedge clk);
    #1 reset = 1'b0;
    compare("pc after reset", 0, pc, 0);
    compare("push after reset", 0, push, 0);
    compare("pull after reset", 0, pull, 0);
    for (int i = 0; i < NUM_ROWS; i++) begin
      instr = t_instr[i];
      input_pins = t_pins[i];
      din = t_din[i];
      full = t_full[i];
      empty = t_empty[i];
      @(negedge clk);       // Strobes settle mid-cycle
      compare("push", i, push, t_push[i]);
      compare("pull", i, pull, t_pull[i]);
      compare("dout", i, dout, t_dout[i]);
      @(posedge clk);
      #1;
      compare("pc", i, pc, t_pc[i]);
      compare("output_pins", i, output_pins, t_opins[i]);
      compare("pin_directions", i, pin_directions, t_dirs[i]);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire
